/* verilog/cache_pkg.sv */
`default_nettype none

package cache_pkg;

    // cache geometry, four ways for the plru tree
    localparam int WAYS        = 4;
    localparam int LINE_BYTES  = 32;
    localparam int LINE_BITS   = 8 * LINE_BYTES;
    localparam int ADDR_BITS   = 32;
    // byte offset inside one line
    localparam int OFFSET_BITS = $clog2(LINE_BYTES);

    typedef logic [LINE_BITS-1:0]    line_t;
    typedef logic [ADDR_BITS-1:0]    addr_t;
    typedef logic [LINE_BYTES-1:0]   wmask_t;
    typedef logic [$clog2(WAYS)-1:0] way_t;
    // one-hot or empty way set
    typedef logic [WAYS-1:0]         waymap_t;

    // controller states
    typedef enum logic [1:0] {
        CS_IDLE,
        CS_COMPARE,
        CS_WRITEBACK,
        CS_ALLOCATE
    } cache_state_t;

    // where a way write comes from
    typedef enum logic [1:0] {
        DS_NONE,
        DS_CPU,
        DS_MEM
    } data_src_t;

    // valid and dirty commands
    typedef enum logic [1:0] {
        FO_IDLE,
        FO_SET,
        FO_CLEAR
    } flag_op_t;

endpackage

`default_nettype wire

/* verilog/cache_way.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_way #(
    parameter int  S_INDEX = 4,
    localparam int S_TAG   = cache_pkg::ADDR_BITS - S_INDEX - cache_pkg::OFFSET_BITS
) (
    input  logic                clk,
    input  logic                rst_n_i,
    input  logic [S_INDEX-1:0]  set_i,
    input  logic                data_we_i,
    input  cache_pkg::wmask_t   wmask_i,
    input  cache_pkg::line_t    wdata_i,
    input  logic                tag_we_i,
    input  logic [S_TAG-1:0]    tag_i,
    input  cache_pkg::flag_op_t valid_op_i,
    input  cache_pkg::flag_op_t dirty_op_i,
    output logic [S_TAG-1:0]    tag_o,
    output cache_pkg::line_t    line_o,
    output logic                valid_o,
    output logic                dirty_o
);
    import cache_pkg::*;

    localparam int SETS = 2 ** S_INDEX;

    // per-set storage, flops with async read
    logic [S_TAG-1:0] tag_q  [SETS];
    line_t            line_q [SETS];
    logic [SETS-1:0]  valid_q;
    logic [SETS-1:0]  dirty_q;

    assign tag_o   = tag_q[set_i];
    assign line_o  = line_q[set_i];
    assign valid_o = valid_q[set_i];
    assign dirty_o = dirty_q[set_i];

    // line and tag payload
    always_ff @(posedge clk) begin
        if (data_we_i) begin
            // only bytes picked by the mask
            for (int b = 0; b < LINE_BYTES; b++) begin
                if (wmask_i[b]) begin
                    line_q[set_i][8*b +: 8] <= wdata_i[8*b +: 8];
                end
            end
        end
        if (tag_we_i) begin
            tag_q[set_i] <= tag_i;
        end
    end

    // valid and dirty follow their commands
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else begin
            case (valid_op_i)
                FO_SET:   valid_q[set_i] <= 1'b1;
                FO_CLEAR: valid_q[set_i] <= 1'b0;
                default:  ;
            endcase
            case (dirty_op_i)
                FO_SET:   dirty_q[set_i] <= 1'b1;
                FO_CLEAR: dirty_q[set_i] <= 1'b0;
                default:  ;
            endcase
        end
    end

    // a fresh tag always comes with a valid line
    a_tag_not_invalidated: assert property (@(posedge clk) disable iff (!rst_n_i)
        tag_we_i |-> (valid_op_i != FO_CLEAR));

endmodule

`default_nettype wire

/* verilog/cache_way_steer.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_way_steer #(
    parameter int S_INDEX = 4
) (
    input  cache_pkg::data_src_t data_src_i,
    input  logic                 tag_we_i,
    input  cache_pkg::flag_op_t  dirty_op_i,
    input  cache_pkg::flag_op_t  valid_op_i,
    input  cache_pkg::waymap_t   hit_map_i,
    input  cache_pkg::waymap_t   victim_map_i,
    input  cache_pkg::line_t     cpu_wdata_i,
    input  cache_pkg::line_t     mem_rdata_i,
    input  cache_pkg::wmask_t    cpu_wmask_i,
    output cache_pkg::waymap_t   data_we_o,
    output cache_pkg::waymap_t   tag_we_o,
    output cache_pkg::wmask_t    wmask_o,
    output cache_pkg::line_t     wdata_o,
    output cache_pkg::flag_op_t  dirty_op_o [cache_pkg::WAYS],
    output cache_pkg::flag_op_t  valid_op_o [cache_pkg::WAYS]
);
    import cache_pkg::*;

    // ways that receive the flag commands
    waymap_t flag_map;

    // index must leave at least one tag bit
    if (S_INDEX < 1 || S_INDEX > ADDR_BITS - OFFSET_BITS - 1) begin : g_bad_index
        $error("cache_way_steer: S_INDEX out of range");
    end

    always_comb begin
        unique case (data_src_i)
            // write hit goes to the hit way
            DS_CPU: data_we_o = hit_map_i;
            // refill goes to the victim
            DS_MEM: data_we_o = victim_map_i;
            default: data_we_o = '0;
        endcase
    end

    // tags only change on allocate
    assign tag_we_o = tag_we_i ? victim_map_i : '0;

    // refill replaces the whole line
    assign wmask_o  = (data_src_i == DS_MEM) ? '1 : cpu_wmask_i;
    assign wdata_o  = (data_src_i == DS_MEM) ? mem_rdata_i : cpu_wdata_i;

    // dirty on write hit targets the hit way, else the victim
    assign flag_map = (data_src_i == DS_CPU) ? hit_map_i : victim_map_i;

    always_comb begin
        for (int w = 0; w < WAYS; w++) begin
            dirty_op_o[w] = flag_map[w] ? dirty_op_i : FO_IDLE;
            valid_op_o[w] = flag_map[w] ? valid_op_i : FO_IDLE;
        end
    end

    // relies on plru and hit maps being one-hot
    a_single_way_write: assert final ($onehot0(data_we_o) && $onehot0(tag_we_o))
        else $error("cache_way_steer: more than one way written");

endmodule

`default_nettype wire

/* verilog/cache_hit_merge.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_hit_merge #(
    parameter int  S_INDEX = 4,
    localparam int S_TAG   = cache_pkg::ADDR_BITS - S_INDEX - cache_pkg::OFFSET_BITS
) (
    input  logic [S_TAG-1:0]   tag_i,
    input  logic [S_INDEX-1:0] set_i,
    input  logic [S_TAG-1:0]   way_tag_i   [cache_pkg::WAYS],
    input  cache_pkg::line_t   way_line_i  [cache_pkg::WAYS],
    input  cache_pkg::waymap_t way_valid_i,
    input  cache_pkg::waymap_t way_dirty_i,
    input  cache_pkg::way_t    victim_way_i,
    input  logic               use_victim_i,
    output logic               hit_o,
    output cache_pkg::way_t    hit_way_o,
    output cache_pkg::waymap_t hit_map_o,
    output cache_pkg::line_t   rdata_o,
    output logic               victim_dirty_o,
    output cache_pkg::addr_t   pmem_address_o
);
    import cache_pkg::*;

    // tag of the line chosen for eviction
    logic [S_TAG-1:0] victim_tag;

    // all ways compared in parallel
    always_comb begin
        hit_way_o = '0;
        for (int w = 0; w < WAYS; w++) begin
            hit_map_o[w] = way_valid_i[w] && (way_tag_i[w] == tag_i);
            // encode the hit way
            if (hit_map_o[w]) begin
                hit_way_o = way_t'(w);
            end
        end
    end

    assign hit_o = |hit_map_o;

    assign victim_tag     = way_tag_i[victim_way_i];
    // invalid lines never need a writeback
    assign victim_dirty_o = way_valid_i[victim_way_i] & way_dirty_i[victim_way_i];

    // victim line during writeback, hit line otherwise
    assign rdata_o = use_victim_i ? way_line_i[victim_way_i] : way_line_i[hit_way_o];

    // writeback uses the stored tag
    // allocate uses the request, both line aligned
    assign pmem_address_o = use_victim_i ?
        {victim_tag, set_i, {OFFSET_BITS{1'b0}}} :
        {tag_i, set_i, {OFFSET_BITS{1'b0}}};

    // a tag lives in one way of a set at most
    a_hit_onehot: assert final ($onehot0(hit_map_o))
        else $error("cache_hit_merge: tag present in several ways");

endmodule

`default_nettype wire

/* verilog/cache_plru.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_plru #(
    parameter int S_INDEX = 4
) (
    input  logic               clk,
    input  logic               rst_n_i,
    input  logic [S_INDEX-1:0] set_i,
    input  logic               update_i,
    input  cache_pkg::way_t    hit_way_i,
    output cache_pkg::way_t    victim_way_o,
    output cache_pkg::waymap_t victim_map_o
);
    import cache_pkg::*;

    localparam int SETS = 2 ** S_INDEX;

    // bit 0 root, bit 1 ways 0/1, bit 2 ways 2/3
    logic [2:0] tree_q [SETS];
    logic [2:0] tree;

    assign tree = tree_q[set_i];

    // follow the tree, 0 means left
    assign victim_way_o = tree[0] ? {1'b1, tree[2]} : {1'b0, tree[1]};
    assign victim_map_o = waymap_t'(1) << victim_way_o;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            tree_q <= '{default: '0};
        end else if (update_i) begin
            // point the root at the other half
            tree_q[set_i][0] <= ~hit_way_i[1];
            // and the leaf pair at the sibling
            if (hit_way_i[1]) begin
                tree_q[set_i][2] <= ~hit_way_i[0];
            end else begin
                tree_q[set_i][1] <= ~hit_way_i[0];
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/cache_control.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_control (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  logic                 mem_read_i,
    input  logic                 mem_write_i,
    input  logic                 hit_i,
    input  logic                 victim_dirty_i,
    input  logic                 pmem_resp_i,
    output logic                 mem_resp_o,
    output logic                 pmem_read_o,
    output logic                 pmem_write_o,
    output cache_pkg::data_src_t data_src_o,
    output logic                 tag_we_o,
    output cache_pkg::flag_op_t  dirty_op_o,
    output cache_pkg::flag_op_t  valid_op_o,
    output logic                 use_victim_o,
    output logic                 plru_update_o
);
    import cache_pkg::*;

    cache_state_t state_q;
    cache_state_t state_d;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= CS_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        // idle defaults with nothing written
        state_d       = state_q;
        mem_resp_o    = 1'b0;
        pmem_read_o   = 1'b0;
        pmem_write_o  = 1'b0;
        data_src_o    = DS_NONE;
        tag_we_o      = 1'b0;
        dirty_op_o    = FO_IDLE;
        valid_op_o    = FO_IDLE;
        use_victim_o  = 1'b0;
        plru_update_o = 1'b0;

        unique case (state_q)
            CS_IDLE: begin
                if (mem_read_i || mem_write_i) begin
                    state_d = CS_COMPARE;
                end
            end
            CS_COMPARE: begin
                if (hit_i) begin
                    // one cycle hit response
                    mem_resp_o    = 1'b1;
                    plru_update_o = 1'b1;
                    if (mem_write_i) begin
                        data_src_o = DS_CPU;
                        dirty_op_o = FO_SET;
                    end
                    state_d = CS_IDLE;
                end else if (victim_dirty_i) begin
                    state_d = CS_WRITEBACK;
                end else begin
                    // clean victim goes straight to refill
                    state_d = CS_ALLOCATE;
                end
            end
            CS_WRITEBACK: begin
                // victim line and address on pmem
                pmem_write_o = 1'b1;
                use_victim_o = 1'b1;
                if (pmem_resp_i) begin
                    state_d = CS_ALLOCATE;
                end
            end
            CS_ALLOCATE: begin
                pmem_read_o = 1'b1;
                if (pmem_resp_i) begin
                    // refill data valid with the resp pulse
                    data_src_o = DS_MEM;
                    tag_we_o   = 1'b1;
                    valid_op_o = FO_SET;
                    dirty_op_o = FO_CLEAR;
                    // look up again to hit the new line
                    state_d    = CS_COMPARE;
                end
            end
            default: state_d = CS_IDLE;
        endcase
    end

    a_pmem_exclusive: assert property (@(posedge clk) disable iff (!rst_n_i)
        !(pmem_read_o && pmem_write_o));

    // response only while the cpu still holds its request
    a_resp_with_req: assert property (@(posedge clk) disable iff (!rst_n_i)
        mem_resp_o |-> (mem_read_i || mem_write_i));

endmodule

`default_nettype wire

/* verilog/cache_top.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_top #(
    parameter int  S_INDEX  = 4,
    localparam int S_OFFSET = cache_pkg::OFFSET_BITS,
    localparam int S_TAG    = cache_pkg::ADDR_BITS - S_INDEX - S_OFFSET
) (
    input  logic              clk,
    input  logic              rst_n_i,
    // cpu side
    input  logic              mem_read_i,
    input  logic              mem_write_i,
    input  cache_pkg::addr_t  mem_address_i,
    input  cache_pkg::line_t  mem_wdata_i,
    input  cache_pkg::wmask_t mem_byte_enable_i,
    output cache_pkg::line_t  mem_rdata_o,
    output logic              mem_resp_o,
    // memory side
    output logic              pmem_read_o,
    output logic              pmem_write_o,
    output cache_pkg::addr_t  pmem_address_o,
    output cache_pkg::line_t  pmem_wdata_o,
    input  cache_pkg::line_t  pmem_rdata_i,
    input  logic              pmem_resp_i
);
    import cache_pkg::*;

    // address fields
    logic [S_TAG-1:0]   tag;
    logic [S_INDEX-1:0] set;

    // controller commands and status
    data_src_t data_src;
    flag_op_t  dirty_op;
    flag_op_t  valid_op;
    logic      tag_we;
    logic      use_victim;
    logic      plru_update;
    logic      hit;
    logic      victim_dirty;

    // per-way buses
    waymap_t          data_we_map;
    waymap_t          tag_we_map;
    wmask_t           way_wmask;
    line_t            way_wdata;
    flag_op_t         way_dirty_op [WAYS];
    flag_op_t         way_valid_op [WAYS];
    logic [S_TAG-1:0] way_tag      [WAYS];
    line_t            way_line     [WAYS];
    waymap_t          way_valid;
    waymap_t          way_dirty;

    // lookup and replacement
    waymap_t hit_map;
    waymap_t victim_map;
    way_t    hit_way;
    way_t    victim_way;
    line_t   rdata;

    assign tag = mem_address_i[ADDR_BITS-1 -: S_TAG];
    assign set = mem_address_i[S_OFFSET +: S_INDEX];

    // one mux feeds both the cpu and the writeback data
    assign mem_rdata_o  = rdata;
    assign pmem_wdata_o = rdata;

    cache_control u_control (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .mem_read_i     (mem_read_i),
        .mem_write_i    (mem_write_i),
        .hit_i          (hit),
        .victim_dirty_i (victim_dirty),
        .pmem_resp_i    (pmem_resp_i),
        .mem_resp_o     (mem_resp_o),
        .pmem_read_o    (pmem_read_o),
        .pmem_write_o   (pmem_write_o),
        .data_src_o     (data_src),
        .tag_we_o       (tag_we),
        .dirty_op_o     (dirty_op),
        .valid_op_o     (valid_op),
        .use_victim_o   (use_victim),
        .plru_update_o  (plru_update)
    );

    cache_way_steer #(.S_INDEX(S_INDEX)) u_steer (
        .data_src_i   (data_src),
        .tag_we_i     (tag_we),
        .dirty_op_i   (dirty_op),
        .valid_op_i   (valid_op),
        .hit_map_i    (hit_map),
        .victim_map_i (victim_map),
        .cpu_wdata_i  (mem_wdata_i),
        .mem_rdata_i  (pmem_rdata_i),
        .cpu_wmask_i  (mem_byte_enable_i),
        .data_we_o    (data_we_map),
        .tag_we_o     (tag_we_map),
        .wmask_o      (way_wmask),
        .wdata_o      (way_wdata),
        .dirty_op_o   (way_dirty_op),
        .valid_op_o   (way_valid_op)
    );

    for (genvar g = 0; g < WAYS; g++) begin : g_way
        cache_way #(.S_INDEX(S_INDEX)) u_way (
            .clk        (clk),
            .rst_n_i    (rst_n_i),
            .set_i      (set),
            .data_we_i  (data_we_map[g]),
            .wmask_i    (way_wmask),
            .wdata_i    (way_wdata),
            .tag_we_i   (tag_we_map[g]),
            .tag_i      (tag),
            .valid_op_i (way_valid_op[g]),
            .dirty_op_i (way_dirty_op[g]),
            .tag_o      (way_tag[g]),
            .line_o     (way_line[g]),
            .valid_o    (way_valid[g]),
            .dirty_o    (way_dirty[g])
        );
    end

    cache_hit_merge #(.S_INDEX(S_INDEX)) u_merge (
        .tag_i          (tag),
        .set_i          (set),
        .way_tag_i      (way_tag),
        .way_line_i     (way_line),
        .way_valid_i    (way_valid),
        .way_dirty_i    (way_dirty),
        .victim_way_i   (victim_way),
        .use_victim_i   (use_victim),
        .hit_o          (hit),
        .hit_way_o      (hit_way),
        .hit_map_o      (hit_map),
        .rdata_o        (rdata),
        .victim_dirty_o (victim_dirty),
        .pmem_address_o (pmem_address_o)
    );

    cache_plru #(.S_INDEX(S_INDEX)) u_plru (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .set_i        (set),
        .update_i     (plru_update),
        .hit_way_i    (hit_way),
        .victim_way_o (victim_way),
        .victim_map_o (victim_map)
    );

endmodule

`default_nettype wire

/* dv/cache_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_tb;
    import cache_pkg::*;

    localparam int          S_INDEX     = 4;
    localparam int          S_TAG       = ADDR_BITS - S_INDEX - OFFSET_BITS;
    localparam int          SETS        = 2 ** S_INDEX;
    localparam int          MEM_LATENCY = 3;
    localparam int          TIMEOUT     = 200;
    localparam logic [31:0] SEED        = 32'hf48e_1b10;

    logic    clk;
    logic    rst_n_i;
    logic    mem_read_i;
    logic    mem_write_i;
    addr_t   mem_address_i;
    line_t   mem_wdata_i;
    wmask_t  mem_byte_enable_i;
    line_t   mem_rdata_o;
    logic    mem_resp_o;
    logic    pmem_read_o;
    logic    pmem_write_o;
    addr_t   pmem_address_o;
    line_t   pmem_wdata_o;
    line_t   pmem_rdata_i;
    logic    pmem_resp_i;

    // memory model state and transfer log
    line_t   mem_q [addr_t];
    int      lat_cnt;
    bit      op_wr_q [$];
    addr_t   op_addr_q [$];
    line_t   op_data_q [$];

    // reference model
    line_t            golden_q [addr_t];
    logic [S_TAG-1:0] tag_m    [SETS][WAYS];
    logic             valid_m  [SETS][WAYS];
    logic             dirty_m  [SETS][WAYS];
    // plru mirror where each node names the half or way it points at
    int               root_half_m [SETS];
    int               left_way_m  [SETS];
    int               right_way_m [SETS];
    logic [31:0]      lfsr_q;
    int               error_count;

    cache_top #(.S_INDEX(S_INDEX)) UUT (
        .clk               (clk),
        .rst_n_i           (rst_n_i),
        .mem_read_i        (mem_read_i),
        .mem_write_i       (mem_write_i),
        .mem_address_i     (mem_address_i),
        .mem_wdata_i       (mem_wdata_i),
        .mem_byte_enable_i (mem_byte_enable_i),
        .mem_rdata_o       (mem_rdata_o),
        .mem_resp_o        (mem_resp_o),
        .pmem_read_o       (pmem_read_o),
        .pmem_write_o      (pmem_write_o),
        .pmem_address_o    (pmem_address_o),
        .pmem_wdata_o      (pmem_wdata_o),
        .pmem_rdata_i      (pmem_rdata_i),
        .pmem_resp_i       (pmem_resp_i)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // fibonacci lfsr with taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // power-up contents seeded from the full line address
    function automatic line_t fill_line(input addr_t a);
        logic [31:0] s;
        line_t       v;
        s = SEED ^ a;
        if (s == 0) begin
            s = SEED;
        end
        for (int i = 0; i < LINE_BITS; i++) begin
            s    = lfsr_step(s);
            v[i] = s[0];
        end
        return v;
    endfunction

    function automatic line_t mem_line(input addr_t a);
        return mem_q.exists(a) ? mem_q[a] : fill_line(a);
    endfunction

    // what the cpu should see at a line address
    function automatic line_t golden_line(input addr_t a);
        return golden_q.exists(a) ? golden_q[a] : fill_line(a);
    endfunction

    function automatic line_t merge_bytes(input line_t old, input line_t wd, input wmask_t m);
        for (int b = 0; b < LINE_BYTES; b++) begin
            if (m[b]) begin
                old[8*b +: 8] = wd[8*b +: 8];
            end
        end
        return old;
    endfunction

    // the victim sits where the root and then its pair point
    function automatic way_t victim_of_set(input int s);
        return way_t'((root_half_m[s] == 1) ? right_way_m[s] : left_way_m[s]);
    endfunction

    // every node on the used way's path turns away from it
    function automatic void touch_path(input int s, input way_t w);
        if (w < 2) begin
            root_half_m[s] = 1;
            left_way_m[s]  = (w == 0) ? 1 : 0;
        end else begin
            root_half_m[s] = 0;
            right_way_m[s] = (w == 2) ? 3 : 2;
        end
    endfunction

    function automatic addr_t make_addr(input logic [S_TAG-1:0] tag, input int set_idx,
                                        input int off);
        return {tag, S_INDEX'(set_idx), OFFSET_BITS'(off)};
    endfunction

    task automatic rand_line(output line_t v);
        for (int i = 0; i < LINE_BITS; i++) begin
            lfsr_q = lfsr_step(lfsr_q);
            v[i]   = lfsr_q[0];
        end
    endtask

    task automatic rand_mask(output wmask_t m);
        for (int i = 0; i < LINE_BYTES; i++) begin
            lfsr_q = lfsr_step(lfsr_q);
            m[i]   = lfsr_q[0];
        end
    endtask

    // fixed latency memory with one resp pulse per transfer
    always @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pmem_resp_i <= 1'b0;
            lat_cnt     <= 0;
        end else if (pmem_resp_i) begin
            pmem_resp_i <= 1'b0;
            lat_cnt     <= 0;
        end else if (pmem_read_o || pmem_write_o) begin
            if (lat_cnt == MEM_LATENCY) begin
                pmem_resp_i <= 1'b1;
                lat_cnt     <= 0;
                op_wr_q.push_back(pmem_write_o);
                op_addr_q.push_back(pmem_address_o);
                if (pmem_write_o) begin
                    mem_q[pmem_address_o] = pmem_wdata_o;
                    op_data_q.push_back(pmem_wdata_o);
                end else begin
                    pmem_rdata_i <= mem_line(pmem_address_o);
                    op_data_q.push_back(mem_line(pmem_address_o));
                end
            end else begin
                lat_cnt <= lat_cnt + 1;
            end
        end
    end

    task automatic stop_on_failure();
        $display("=== FAIL ===");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_line(input line_t got, input line_t exp, input string what);
        if (got !== exp) begin
            error_count++;
            $display("Error at %0t: %s, got %h expected %h", $time, what, got, exp);
            stop_on_failure();
        end
    endtask

    task automatic check_addr(input addr_t got, input addr_t exp, input string what);
        if (got !== exp) begin
            error_count++;
            $display("Error at %0t: %s, got %h expected %h", $time, what, got, exp);
            stop_on_failure();
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            error_count++;
            $display("Error at %0t: %s, got %b expected %b", $time, what, got, exp);
            stop_on_failure();
        end
    endtask

    // one cpu request checked against the reference model
    task automatic cache_access(input logic wr, input addr_t a, input line_t wd,
                                input wmask_t m);
        addr_t            line_a;
        int               set_idx;
        logic [S_TAG-1:0] tag;
        way_t             way;
        way_t             victim;
        logic             pred_hit;
        logic             pred_wb;
        addr_t            wb_a;
        line_t            wb_line;
        line_t            got;
        int               n;
        int               n_ops;
        line_a   = {a[ADDR_BITS-1:OFFSET_BITS], {OFFSET_BITS{1'b0}}};
        set_idx  = a[OFFSET_BITS +: S_INDEX];
        tag      = a[ADDR_BITS-1 -: S_TAG];
        pred_hit = 1'b0;
        way      = '0;
        for (int w = 0; w < WAYS; w++) begin
            if (valid_m[set_idx][w] && tag_m[set_idx][w] == tag) begin
                pred_hit = 1'b1;
                way      = way_t'(w);
            end
        end
        victim  = victim_of_set(set_idx);
        pred_wb = !pred_hit && valid_m[set_idx][victim] && dirty_m[set_idx][victim];
        wb_a    = make_addr(tag_m[set_idx][victim], set_idx, 0);
        wb_line = golden_line(wb_a);
        op_wr_q.delete();
        op_addr_q.delete();
        op_data_q.delete();

        @(posedge clk);
        mem_read_i        <= !wr;
        mem_write_i       <= wr;
        mem_address_i     <= a;
        mem_wdata_i       <= wd;
        mem_byte_enable_i <= m;
        if (pred_hit) begin
            // lookup cycle then the response cycle
            @(posedge clk);
            check_bit(mem_resp_o, 1'b0, "no response in the sampling cycle");
            check_bit(pmem_read_o || pmem_write_o, 1'b0, "memory idle on hit");
            @(posedge clk);
            check_bit(mem_resp_o, 1'b1, "hit response one cycle after request");
            check_bit(pmem_read_o || pmem_write_o, 1'b0, "memory idle on hit");
        end else begin
            n = 0;
            do begin
                @(posedge clk);
                n++;
                if (n > TIMEOUT) begin
                    $display("timeout: no mem_resp_o for address %h", a);
                    stop_on_failure();
                end
            end while (!mem_resp_o);
        end
        got = mem_rdata_o;
        mem_read_i  <= 1'b0;
        mem_write_i <= 1'b0;

        // memory traffic against the prediction
        n_ops = pred_hit ? 0 : (pred_wb ? 2 : 1);
        check_bit(op_wr_q.size() == n_ops, 1'b1, "number of memory transfers");
        if (pred_wb) begin
            check_bit(op_wr_q[0], 1'b1, "writeback comes before refill");
            check_addr(op_addr_q[0], wb_a, "writeback address");
            check_line(op_data_q[0], wb_line, "writeback data");
        end
        if (!pred_hit) begin
            check_bit(op_wr_q[n_ops-1], 1'b0, "refill is a read");
            check_addr(op_addr_q[n_ops-1], line_a, "refill address");
            tag_m[set_idx][victim]   = tag;
            valid_m[set_idx][victim] = 1'b1;
            dirty_m[set_idx][victim] = 1'b0;
            way = victim;
        end
        touch_path(set_idx, way);
        if (wr) begin
            golden_q[line_a]      = merge_bytes(golden_line(line_a), wd, m);
            dirty_m[set_idx][way] = 1'b1;
        end else begin
            check_line(got, golden_line(line_a), "read data");
        end
    endtask

    task automatic reset_outputs_low();
        @(posedge clk);
        check_bit(mem_resp_o, 1'b0, "mem_resp_o after reset");
        check_bit(pmem_read_o, 1'b0, "pmem_read_o after reset");
        check_bit(pmem_write_o, 1'b0, "pmem_write_o after reset");
        cache_access(1'b0, 32'h0000_1020, '0, '0);
        check_bit(op_wr_q.size() != 0, 1'b1, "first read after reset misses");
    endtask

    task automatic cold_read_miss();
        // unaligned offset so the refill address must be aligned
        cache_access(1'b0, 32'h1234_5674, '0, '0);
        check_bit(op_wr_q.size() == 1, 1'b1, "cold miss has no writeback");
    endtask

    task automatic repeated_read_hit();
        cache_access(1'b0, 32'h1234_5660, '0, '0);
        check_bit(op_wr_q.size() == 0, 1'b1, "repeated read hits");
    endtask

    task automatic masked_write_hit();
        line_t  wd;
        wmask_t m;
        rand_line(wd);
        rand_mask(m);
        cache_access(1'b1, 32'h1234_5668, wd, m);
        cache_access(1'b0, 32'h1234_5660, '0, '0);
    endtask

    task automatic dirty_victim_writeback();
        line_t  wd;
        wmask_t m;
        rand_line(wd);
        rand_mask(m);
        cache_access(1'b0, make_addr(23'h000a1, 5, 0), '0, '0);
        cache_access(1'b1, make_addr(23'h000a1, 5, 4), wd, m);
        // three more tags fill the set and the fifth evicts
        for (int i = 1; i < 5; i++) begin
            cache_access(1'b0, make_addr(23'h000a1 + 23'(i * 'h111), 5, 8), '0, '0);
        end
        check_bit(op_wr_q.size() == 2, 1'b1, "fifth tag writes back the dirty line");
    endtask

    task automatic clean_victim_eviction();
        cache_access(1'b0, make_addr(23'h7f0c3, 5, 0), '0, '0);
        check_bit(op_wr_q[0], 1'b0, "clean eviction starts with a read");
    endtask

    initial begin
        rst_n_i           = 1'b0;
        mem_read_i        = 1'b0;
        mem_write_i       = 1'b0;
        mem_address_i     = '0;
        mem_wdata_i       = '0;
        mem_byte_enable_i = '0;
        pmem_rdata_i      = '0;
        pmem_resp_i       = 1'b0;
        lfsr_q            = SEED;
        error_count       = 0;
        for (int s = 0; s < SETS; s++) begin
            // all nodes point left after reset
            root_half_m[s] = 0;
            left_way_m[s]  = 0;
            right_way_m[s] = 2;
            for (int w = 0; w < WAYS; w++) begin
                tag_m[s][w]   = '0;
                valid_m[s][w] = 1'b0;
                dirty_m[s][w] = 1'b0;
            end
        end
        repeat (3) @(posedge clk);
        rst_n_i <= 1'b1;

        reset_outputs_low();
        cold_read_miss();
        repeated_read_hit();
        masked_write_hit();
        dirty_victim_writeback();
        clean_victim_eviction();

        repeat (2) @(posedge clk);
        if (error_count == 0) begin
            $display("=== PASS ===");
            $finish;
        end else begin
            stop_on_failure();
        end
    end

endmodule

`default_nettype wire

/* files.f */
verilog/cache_pkg.sv
verilog/cache_way.sv
verilog/cache_way_steer.sv
verilog/cache_hit_merge.sv
verilog/cache_plru.sv
verilog/cache_control.sv
verilog/cache_top.sv
dv/cache_tb.sv
